/* sim/lbcVectors.txt */
# name dcOff icOff kind write sign size addr wdata iaddr resp0 resp1, then per bus request
# addr be line wdata (two sets), then dataOut instrOut; all numbers in hex
lbUnsOff0 0 0 data 0 0 0 1000 0 0 8899aabb 0 1000 1 1 0 0 0 0 0 bb 0
lbSgnOff1 0 0 data 0 1 0 1005 0 0 8899aabb 0 1000 2 1 0 0 0 0 0 ffffffaa 0
lbSgnOff2 0 0 data 0 1 0 100a 0 0 12345678 0 1000 4 1 0 0 0 0 0 34 0
lbUnsOff3 0 0 data 0 0 0 100f 0 0 8899aabb 0 1000 8 1 0 0 0 0 0 88 0
lhSgnOff2 0 0 data 0 1 1 2002 0 0 8899aabb 0 2000 c 1 0 0 0 0 0 ffff8899 0
lhUnsOff0 0 0 data 0 0 1 2010 0 0 8899aabb 0 2010 3 1 0 0 0 0 0 aabb 0
lhSgnPos 0 0 data 0 1 1 2014 0 0 12345678 0 2010 3 1 0 0 0 0 0 5678 0
lwCached 0 0 data 0 0 2 3004 0 0 12345678 0 3000 f 1 0 0 0 0 0 12345678 0
lwUncached 1 0 data 0 0 2 3008 0 0 cafef00d 0 3008 f 0 0 0 0 0 0 cafef00d 0
lbUncSgn 1 0 data 0 1 0 300b 0 0 8899aabb 0 3008 8 0 0 0 0 0 0 ffffff88 0
sbOff1 0 0 data 1 0 0 4001 a5 0 0 0 4000 2 0 a5a5a5a5 0 0 0 0 0 0
shOff2 0 0 data 1 0 1 4006 beef 0 0 0 4004 c 0 beefbeef 0 0 0 0 0 0
swWord 0 0 data 1 0 2 4008 deadbeef 0 0 0 4008 f 0 deadbeef 0 0 0 0 0 0
sbUncOff0 1 0 data 1 0 0 400c 12345677 0 0 0 400c 1 0 77777777 0 0 0 0 0 0
ifLine 0 0 instr 0 0 0 0 0 8024 00112233 0 8020 f 1 0 0 0 0 0 0 112233
ifWord 0 1 instr 0 0 0 0 0 8026 44556677 0 8024 f 0 0 0 0 0 0 0 44556677
bothCached 0 0 both 0 1 0 5003 0 9018 8899aabb a1b2c3d4 5000 8 1 0 9010 f 1 0 ffffff88 a1b2c3d4
bothUnc 1 1 both 1 0 2 5104 0badcafe 9104 0 55aa55aa 5104 f 0 0badcafe 9104 f 0 0 0 55aa55aa

/* project.f */
rtl/lbcCorePkg.sv
rtl/lbcBusPkg.sv
rtl/loadAligner.sv
rtl/dataReqPath.sv
rtl/instrReqPath.sv
rtl/sysBusPort.sv
rtl/lbcTop.sv
sim/lbcTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := lbcTb
FILELIST  := project.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/lbcTb.sv */
`timescale 1ns/1ps

module lbcTb;

  localparam int waitLimit = 60;   // Cycles allowed per wait.
  localparam logic [63:0] kindData  = 64'("data");
  localparam logic [63:0] kindInstr = 64'("instr");
  localparam logic [63:0] kindBoth  = 64'("both");

  logic               IDCLOCKI;
  logic               reset;
  logic               dataStrobe;
  lbcCorePkg::dataReq dataIn;
  logic               instrStrobe;
  logic [31:0]        instrAddr;
  logic               cfgDcOff;
  logic               cfgIcOff;
  logic               dataBusy;
  logic               instrBusy;
  logic               dataValid;
  logic [31:0]        dataOut;
  logic               instrValid;
  logic [31:0]        instrOut;
  logic               sysStrobe;
  lbcBusPkg::sysReq   sysOut;
  logic               sysRespValid;
  logic [31:0]        sysRespData;

  integer seed = 32'h869dfbef;
  int     cycleCount = 0;
  int     respCycle = 0;   // Cycle in which the last response was on the bus.
  string  testName = "reset";

  // ====================
  // Current vector
  // ====================

  logic [8*24-1:0] nameBits;
  logic [63:0]     kindBits;
  logic            vDcOff;
  logic            vIcOff;
  logic            vWrite;
  logic            vSign;
  logic [1:0]      vSize;
  logic [31:0]     vAddr;
  logic [31:0]     vWdata;
  logic [31:0]     vIaddr;
  logic [31:0]     respWord [2];
  logic [31:0]     expAddr [2];
  logic [3:0]      expBe [2];
  logic            expLine [2];
  logic [31:0]     expWdata [2];
  logic [31:0]     expData;
  logic [31:0]     expInstr;

  lbcTop #(
    .addrWidth (32)
  ) dut_i (
    .IDCLOCKI     (IDCLOCKI),
    .reset        (reset),
    .dataStrobe   (dataStrobe),
    .dataIn       (dataIn),
    .instrStrobe  (instrStrobe),
    .instrAddr    (instrAddr),
    .cfgDcOff     (cfgDcOff),
    .cfgIcOff     (cfgIcOff),
    .dataBusy     (dataBusy),
    .instrBusy    (instrBusy),
    .dataValid    (dataValid),
    .dataOut      (dataOut),
    .instrValid   (instrValid),
    .instrOut     (instrOut),
    .sysStrobe    (sysStrobe),
    .sysOut       (sysOut),
    .sysRespValid (sysRespValid),
    .sysRespData  (sysRespData)
  );

  initial
  begin
    IDCLOCKI = 1'b0;
    forever
      #50 IDCLOCKI = ~IDCLOCKI;
  end

  always @(posedge IDCLOCKI)
    cycleCount <= cycleCount + 1;

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
      stopRun($sformatf("ERROR %0s %0s: expected %h, actual %h",
                        testName, what, expected, actual));
  endtask

  function automatic string trimName(input logic [8*24-1:0] bits);
    string text;
    text = "";
    for (int i = 23; i >= 0; i--)
    begin
      if (bits[8*i +: 8] != 8'd0)
        text = $sformatf("%s%c", text, bits[8*i +: 8]);
    end
    return text;
  endfunction

  task automatic verifyIdle(input string tag);
    checkValue({tag, " sysStrobe"}, 32'd0, 32'(sysStrobe));
    checkValue({tag, " dataBusy"}, 32'd0, 32'(dataBusy));
    checkValue({tag, " instrBusy"}, 32'd0, 32'(instrBusy));
    checkValue({tag, " dataValid"}, 32'd0, 32'(dataValid));
    checkValue({tag, " instrValid"}, 32'd0, 32'(instrValid));
  endtask

  // Samples on falling edges, where outputs are settled.
  task automatic awaitHigh(input bit forValid);
    int waited;
    waited = 0;
    @(negedge IDCLOCKI);
    while (!(forValid ? (dataValid || instrValid) : sysStrobe))
    begin
      waited++;
      if (waited > waitLimit)
        stopRun($sformatf("Test %0s timed out waiting for %0s", testName,
                          forValid ? "a result valid" : "sysStrobe"));
      @(negedge IDCLOCKI);
    end
  endtask

  // ====================
  // System bus model
  // ====================

  task automatic respond(input logic [31:0] word);
    int delay;
    delay = 1 + ({$random(seed)} % 4);
    repeat (delay) @(posedge IDCLOCKI);
    sysRespValid <= 1'b1;
    sysRespData  <= word;
    @(negedge IDCLOCKI);
    respCycle = cycleCount;
    @(posedge IDCLOCKI);
    sysRespValid <= 1'b0;
  endtask

  task automatic serveBus(input bit doData, input bit doInstr);
    bit isData;
    int count;
    count = (doData && doInstr) ? 2 : 1;
    for (int i = 0; i < count; i++)
    begin
      isData = doData && (i == 0);   // Data is issued first.
      awaitHigh(1'b0);
      checkValue("sysOut.addr", expAddr[i], sysOut.addr);
      checkValue("sysOut.be", 32'(expBe[i]), 32'(sysOut.be));
      checkValue("sysOut.line", 32'(expLine[i]), 32'(sysOut.line));
      checkValue("sysOut.wdata", expWdata[i], sysOut.wdata);
      checkValue("sysOut.write", 32'(isData && vWrite), 32'(sysOut.write));
      checkValue("sysOut.uncached", 32'(isData ? vDcOff : vIcOff),
                 32'(sysOut.uncached));
      respond(respWord[i]);
    end
  endtask

  task automatic watchResults(input bit doData, input bit doInstr);
    bit isData;
    int count;
    count = (doData && doInstr) ? 2 : 1;
    for (int i = 0; i < count; i++)
    begin
      isData = doData && (i == 0);   // Data goes first.
      awaitHigh(1'b1);
      checkValue("dataValid", 32'(isData), 32'(dataValid));
      checkValue("instrValid", 32'(!isData), 32'(instrValid));
      checkValue("valid latency", 32'(respCycle + 1), 32'(cycleCount));
      if (isData && !vWrite)
        checkValue("dataOut", expData, dataOut);
      if (!isData)
        checkValue("instrOut", expInstr, instrOut);
      @(negedge IDCLOCKI);
      checkValue("single valid pulse", 32'd0, 32'(dataValid || instrValid));
      if (isData)
        checkValue("dataBusy released", 32'd0, 32'(dataBusy));
      else
        checkValue("instrBusy released", 32'd0, 32'(instrBusy));
      if (isData && doInstr)
        checkValue("instrBusy held", 32'd1, 32'(instrBusy));
    end
  endtask

  task automatic issueTiming(input bit doData, input bit doInstr);
    @(negedge IDCLOCKI);
    checkValue("sysStrobe before issue", 32'd0, 32'(sysStrobe));
    @(posedge IDCLOCKI);
    dataStrobe  <= 1'b0;
    instrStrobe <= 1'b0;
    @(negedge IDCLOCKI);
    checkValue("sysStrobe after strobe", 32'd1, 32'(sysStrobe));
    checkValue("dataBusy", 32'(doData), 32'(dataBusy));
    checkValue("instrBusy", 32'(doInstr), 32'(instrBusy));
  endtask

  task automatic runVector();
    lbcCorePkg::dataReq req;
    bit doData;
    bit doInstr;
    doData  = (kindBits == kindData) || (kindBits == kindBoth);
    doInstr = (kindBits == kindInstr) || (kindBits == kindBoth);
    if (!doData && !doInstr)
      stopRun($sformatf("Test %0s has an unknown access kind", testName));
    req.write = vWrite;
    req.sign  = vSign;
    req.size  = lbcCorePkg::accessSize'(vSize);
    req.addr  = vAddr;
    req.wdata = vWdata;
    @(posedge IDCLOCKI);
    cfgDcOff    <= vDcOff;
    cfgIcOff    <= vIcOff;
    dataIn      <= req;
    instrAddr   <= vIaddr;
    dataStrobe  <= doData;
    instrStrobe <= doInstr;
    fork
      serveBus(doData, doInstr);
      watchResults(doData, doInstr);
      issueTiming(doData, doInstr);
    join
  endtask

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    int fd;
    int fields;
    int vectors;
    string line;
    vectors      = 0;
    reset        = 1'b1;
    dataStrobe   = 1'b0;
    dataIn       = '0;
    instrStrobe  = 1'b0;
    instrAddr    = 32'd0;
    cfgDcOff     = 1'b0;
    cfgIcOff     = 1'b0;
    sysRespValid = 1'b0;
    sysRespData  = 32'd0;
    repeat (3)
    begin
      @(posedge IDCLOCKI);
      @(negedge IDCLOCKI);
      verifyIdle("during reset");
    end
    @(posedge IDCLOCKI);
    reset <= 1'b0;   // Fourth edge was the last in reset.
    repeat (3)
    begin
      @(negedge IDCLOCKI);
      verifyIdle("after reset");
    end
    fd = $fopen("sim/lbcVectors.txt", "r");
    if (fd == 0)
      stopRun("Could not open the vector file sim/lbcVectors.txt");
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != 8'h23)   // Skip # lines.
      begin
        nameBits = '0;
        kindBits = '0;
        fields = $sscanf(line,
          "%s %h %h %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          nameBits, vDcOff, vIcOff, kindBits, vWrite, vSign, vSize, vAddr,
          vWdata, vIaddr, respWord[0], respWord[1], expAddr[0], expBe[0],
          expLine[0], expWdata[0], expAddr[1], expBe[1], expLine[1],
          expWdata[1], expData, expInstr);
        if (fields != 22)
          stopRun($sformatf("Malformed line in the vector file: %s", line));
        testName = trimName(nameBits);
        runVector();
        vectors++;
      end
    end
    $fclose(fd);
    if (vectors == 0)
      stopRun("The vector file holds no vectors");
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* rtl/lbcTop.sv */
`timescale 1ns/1ps

module lbcTop #(
  parameter int addrWidth = 32
) (
  input  logic               IDCLOCKI,
  input  logic               reset,
  // Core side.
  input  logic               dataStrobe,
  input  lbcCorePkg::dataReq dataIn,
  input  logic               instrStrobe,
  input  logic [31:0]        instrAddr,
  input  logic               cfgDcOff,
  input  logic               cfgIcOff,
  output logic               dataBusy,
  output logic               instrBusy,
  output logic               dataValid,
  output logic [31:0]        dataOut,
  output logic               instrValid,
  output logic [31:0]        instrOut,
  // System side.
  output logic               sysStrobe,
  output lbcBusPkg::sysReq   sysOut,
  input  logic               sysRespValid,
  input  logic [31:0]        sysRespData
);

  logic                dataPending;
  logic                instrPending;
  logic                dataGrant;
  logic                instrGrant;
  lbcBusPkg::sysReq    dataRequest;
  lbcBusPkg::sysReq    instrRequest;
  lbcCorePkg::loadInfo loadFields;

  dataReqPath #(
    .addrWidth (addrWidth)
  ) dataPath_i (
    .IDCLOCKI   (IDCLOCKI),
    .reset      (reset),
    .dataStrobe (dataStrobe),
    .dataIn     (dataIn),
    .cfgDcOff   (cfgDcOff),
    .grant      (dataGrant),
    .done       (dataValid),
    .pending    (dataPending),
    .busy       (dataBusy),
    .request    (dataRequest),
    .loadFields (loadFields)
  );

  instrReqPath #(
    .addrWidth (addrWidth)
  ) instrPath_i (
    .IDCLOCKI    (IDCLOCKI),
    .reset       (reset),
    .instrStrobe (instrStrobe),
    .instrAddr   (instrAddr),
    .cfgIcOff    (cfgIcOff),
    .grant       (instrGrant),
    .done        (instrValid),
    .pending     (instrPending),
    .busy        (instrBusy),
    .request     (instrRequest)
  );

  sysBusPort busPort_i (
    .IDCLOCKI     (IDCLOCKI),
    .reset        (reset),
    .dataPending  (dataPending),
    .instrPending (instrPending),
    .dataRequest  (dataRequest),
    .instrRequest (instrRequest),
    .loadFields   (loadFields),
    .sysRespValid (sysRespValid),
    .sysRespData  (sysRespData),
    .dataGrant    (dataGrant),
    .instrGrant   (instrGrant),
    .sysStrobe    (sysStrobe),
    .sysOut       (sysOut),
    .dataValid    (dataValid),
    .instrValid   (instrValid),
    .dataOut      (dataOut),
    .instrOut     (instrOut)
  );

endmodule

/* rtl/sysBusPort.sv */
`timescale 1ns/1ps

module sysBusPort (
  input  logic                IDCLOCKI,
  input  logic                reset,
  input  logic                dataPending,
  input  logic                instrPending,
  input  lbcBusPkg::sysReq    dataRequest,
  input  lbcBusPkg::sysReq    instrRequest,
  input  lbcCorePkg::loadInfo loadFields,
  input  logic                sysRespValid,
  input  logic [31:0]         sysRespData,
  output logic                dataGrant,
  output logic                instrGrant,
  output logic                sysStrobe,
  output lbcBusPkg::sysReq    sysOut,
  output logic                dataValid,
  output logic                instrValid,
  output logic [31:0]         dataOut,
  output logic [31:0]         instrOut
);

  logic                outstanding;
  logic                servingData;   // Outstanding request came from the data path.
  lbcBusPkg::sysResp   resp;
  lbcCorePkg::loadInfo fieldsHeld;

  // ====================
  // Arbitration
  // ====================

  // One request on the bus at a time, data first.
  assign dataGrant  = dataPending && !outstanding;
  assign instrGrant = instrPending && !dataPending && !outstanding;
  assign sysStrobe  = dataGrant || instrGrant;

  // Both request sources are registers in the paths.
  assign sysOut = instrGrant ? instrRequest : dataRequest;

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      outstanding <= 1'b0;
      servingData <= 1'b0;
    end
    else if (sysStrobe)
    begin
      outstanding <= 1'b1;
      servingData <= dataGrant;
    end
    else if (sysRespValid)
      outstanding <= 1'b0;
  end

  // ====================
  // Response
  // ====================

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
      resp.valid <= 1'b0;
    else
      resp.valid <= sysRespValid;
  end

  always_ff @(posedge IDCLOCKI)
  begin
    resp.data <= sysRespData;
    if (dataGrant)
      fieldsHeld <= loadFields;   // Alignment of the load in flight.
  end

  assign dataValid  = resp.valid && servingData;
  assign instrValid = resp.valid && !servingData;
  assign instrOut   = resp.data;

  loadAligner aligner_i (
    .rawData (resp.data),
    .fields  (fieldsHeld),
    .aligned (dataOut)
  );

  respNeedsRequest: assert property (@(posedge IDCLOCKI) disable iff (reset)
    sysRespValid |-> outstanding);

endmodule

/* rtl/instrReqPath.sv */
`timescale 1ns/1ps

module instrReqPath #(
  parameter int addrWidth = 32
) (
  input  logic             IDCLOCKI,
  input  logic             reset,
  input  logic             instrStrobe,
  input  logic [31:0]      instrAddr,
  input  logic             cfgIcOff,
  input  logic             grant,
  input  logic             done,
  output logic             pending,
  output logic             busy,
  output lbcBusPkg::sysReq request
);

  localparam int lineShift = $clog2(lbcBusPkg::lineBytes);
  localparam logic [31:0] lineMask = ~((32'd1 << lineShift) - 32'd1);
  localparam logic [31:0] addrKeep =
    (addrWidth >= 32) ? 32'hFFFF_FFFF : ((32'd1 << addrWidth) - 32'd1);

  logic [31:0] fetchAddr;

  // Line fill when cached, single word otherwise.
  assign fetchAddr = cfgIcOff ? (instrAddr & addrKeep & 32'hFFFF_FFFC)
                              : (instrAddr & addrKeep & lineMask);

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      pending <= 1'b0;
      busy    <= 1'b0;
    end
    else if (instrStrobe)
    begin
      pending <= 1'b1;
      busy    <= 1'b1;
    end
    else
    begin
      if (grant)
        pending <= 1'b0;
      if (done)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge IDCLOCKI)
  begin
    if (instrStrobe)
    begin
      request.addr     <= fetchAddr;
      request.write    <= 1'b0;
      request.line     <= !cfgIcOff;
      request.be       <= 4'b1111;
      request.wdata    <= 32'd0;
      request.uncached <= cfgIcOff;
    end
  end

  strobeWhileBusy: assert property (@(posedge IDCLOCKI) disable iff (reset)
    instrStrobe |-> !busy);

endmodule

/* rtl/dataReqPath.sv */
`timescale 1ns/1ps

module dataReqPath #(
  parameter int addrWidth = 32
) (
  input  logic                IDCLOCKI,
  input  logic                reset,
  input  logic                dataStrobe,
  input  lbcCorePkg::dataReq  dataIn,
  input  logic                cfgDcOff,
  input  logic                grant,
  input  logic                done,
  output logic                pending,
  output logic                busy,
  output lbcBusPkg::sysReq    request,
  output lbcCorePkg::loadInfo loadFields
);

  localparam int lineShift = $clog2(lbcBusPkg::lineBytes);
  localparam logic [31:0] lineMask = ~((32'd1 << lineShift) - 32'd1);
  localparam logic [31:0] addrKeep =
    (addrWidth >= 32) ? 32'hFFFF_FFFF : ((32'd1 << addrWidth) - 32'd1);

  logic [3:0]       byteEn;
  logic [31:0]      laneData;
  logic             lineRead;
  lbcBusPkg::sysReq nextReq;

  // ====================
  // Lanes and enables
  // ====================

  always_comb
  begin
    case (dataIn.size)
      lbcCorePkg::sizeByte:
      begin
        byteEn   = 4'b0001 << dataIn.addr[1:0];
        laneData = {4{dataIn.wdata[7:0]}};
      end
      lbcCorePkg::sizeHalf:
      begin
        byteEn   = dataIn.addr[1] ? 4'b1100 : 4'b0011;
        laneData = {2{dataIn.wdata[15:0]}};
      end
      default:
      begin
        byteEn   = 4'b1111;
        laneData = dataIn.wdata;
      end
    endcase
  end

  assign lineRead = !dataIn.write && !cfgDcOff;   // Cached reads fill a line.

  always_comb
  begin
    nextReq.addr     = lineRead ? (dataIn.addr & addrKeep & lineMask)
                                : (dataIn.addr & addrKeep & 32'hFFFF_FFFC);
    nextReq.write    = dataIn.write;
    nextReq.line     = lineRead;
    nextReq.be       = byteEn;
    nextReq.wdata    = laneData;
    nextReq.uncached = cfgDcOff;
  end

  always_ff @(posedge IDCLOCKI)
  begin
    if (reset)
    begin
      pending <= 1'b0;
      busy    <= 1'b0;
    end
    else if (dataStrobe)
    begin
      pending <= 1'b1;
      busy    <= 1'b1;
    end
    else
    begin
      if (grant)
        pending <= 1'b0;
      if (done)
        busy <= 1'b0;   // Held until the load or store completes.
    end
  end

  always_ff @(posedge IDCLOCKI)
  begin
    if (dataStrobe)
    begin
      request           <= nextReq;
      loadFields.size   <= dataIn.size;
      loadFields.sign   <= dataIn.sign;
      loadFields.offset <= dataIn.addr[1:0];
    end
  end

  strobeWhileBusy: assert property (@(posedge IDCLOCKI) disable iff (reset)
    dataStrobe |-> !busy);

endmodule

/* rtl/loadAligner.sv */
`timescale 1ns/1ps

module loadAligner (
  input  logic [31:0]         rawData,
  input  lbcCorePkg::loadInfo fields,
  output logic [31:0]         aligned
);

  logic [31:0] shifted;

  assign shifted = rawData >> {fields.offset, 3'b000};   // Addressed byte to lane 0.

  always_comb
  begin
    case (fields.size)
      lbcCorePkg::sizeByte:
      begin
        if (fields.sign)
          aligned = {{24{shifted[7]}}, shifted[7:0]};
        else
          aligned = {24'd0, shifted[7:0]};
      end
      lbcCorePkg::sizeHalf:
      begin
        if (fields.sign)
          aligned = {{16{shifted[15]}}, shifted[15:0]};
        else
          aligned = {16'd0, shifted[15:0]};
      end
      default:
        aligned = shifted;   // Full word.
    endcase
  end

endmodule

/* rtl/lbcBusPkg.sv */
package lbcBusPkg;

  // ====================
  // Line geometry
  // ====================

  localparam int lineBytes = 16;

  // ====================
  // System request
  // ====================

  typedef struct packed
  {
    logic [31:0] addr;
    logic        write;
    logic        line;      // Full line transfer.
    logic [3:0]  be;
    logic [31:0] wdata;
    logic        uncached;
  } sysReq;

  // Response word from the system bus.
  typedef struct packed
  {
    logic        valid;
    logic [31:0] data;
  } sysResp;

endpackage

/* rtl/lbcCorePkg.sv */
package lbcCorePkg;

  // ====================
  // Access size
  // ====================

  typedef enum logic [1:0]
  {
    sizeByte = 2'd0,
    sizeHalf = 2'd1,
    sizeWord = 2'd2
  } accessSize;

  // ====================
  // Core data access
  // ====================

  typedef struct packed
  {
    logic        write;   // Store when set.
    logic        sign;    // Sign-extend loads.
    accessSize   size;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dataReq;

  // Load return fields, kept for the aligner.
  typedef struct packed
  {
    accessSize  size;
    logic       sign;
    logic [1:0] offset;
  } loadInfo;

endpackage
